// ==== hw/uart_regs_pkg.sv ====
package uart_regs_pkg;

    // ============================================================
    // clock and line rate
    // ============================================================
    localparam int CLK_FREQ   = 25_000_000;
    localparam int BAUD_RATE  = 1_000_000;
    localparam int BAUD_RATIO = CLK_FREQ / BAUD_RATE;   // cycles per bit.
    localparam int BAUD_CNT_W = $clog2(BAUD_RATIO);

    // character framing.
    localparam int DATA_WIDTH  = 8;
    localparam int BIT_CNT_W   = $clog2(DATA_WIDTH);
    localparam int FRAME_BITS  = DATA_WIDTH + 2;        // start, data, stop.
    localparam int FRAME_CNT_W = $clog2(FRAME_BITS);

    // register bank.
    localparam int REG_COUNT = 16;

    // ============================================================
    // types
    // ============================================================
    typedef logic [DATA_WIDTH-1:0]        byte_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;

    // ============================================================
    // command byte and replies
    // ============================================================
    // bit 7 set selects a write, low nibble is the address.
    localparam int    CMD_WRITE_BIT = 7;
    localparam byte_t CMD_RSVD_MASK = 8'h70;   // must read as zero.

    localparam byte_t REPLY_ACK = 8'hA5;
    localparam byte_t REPLY_NAK = 8'h5A;

endpackage

// ==== hw/bus_ifs.sv ====
`timescale 1ns/1ps

// byte stream, one transfer per cycle with tvalid and tready high.
interface axis_if;

    import uart_regs_pkg::*;

    byte_t tdata;
    logic  tvalid;
    logic  tready;

    modport master (
        output tdata,
        output tvalid,
        input  tready
    );

    modport slave (
        input  tdata,
        input  tvalid,
        output tready
    );

endinterface

// four-phase register port.
interface reg_if;

    import uart_regs_pkg::*;

    logic      req;
    logic      we;
    reg_addr_t addr;
    byte_t     wdata;
    logic      ack;
    byte_t     rdata;

    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport slave (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

// ==== hw/axis_uart_rx.sv ====
`timescale 1ns/1ps

module axis_uart_rx (
    input  logic   clk_i,
    input  logic   arstn_i,
    input  logic   rx_i,
    axis_if.master m_axis
);

    import uart_regs_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        STOP,
        WAIT
    } rx_state_t;

    rx_state_t             state;
    logic [1:0]            rx_sync;
    logic                  rx_s;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    byte_t                 rx_shift;
    logic                  baud_done;
    logic                  last_bit;
    logic                  fire;

    // two flops against metastability on the line.
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx_i};
        end
    end

    assign rx_s = rx_sync[1];

    // half a bit in START, a full bit everywhere else.
    assign baud_done = (baud_cnt == BAUD_CNT_W'(BAUD_RATIO - 1)) ||
                       ((state == START) && (baud_cnt == BAUD_CNT_W'(BAUD_RATIO / 2 - 1)));
    assign last_bit  = (bit_cnt == BIT_CNT_W'(DATA_WIDTH - 1));
    assign fire      = m_axis.tvalid && m_axis.tready;

    // ============================================================
    // state machine
    // ============================================================
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (!rx_s) begin
                        state <= START;
                    end
                end
                START: begin
                    if (baud_done) begin
                        state <= rx_s ? IDLE : DATA;   // glitch, not a start bit.
                    end
                end
                DATA: begin
                    if (baud_done && last_bit) begin
                        state <= STOP;
                    end
                end
                STOP: begin
                    if (baud_done) begin
                        state <= IDLE;                  // byte lost if not taken.
                    end else if (fire) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (baud_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
        end else if ((state == IDLE) || baud_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            bit_cnt <= '0;
        end else if (state != DATA) begin
            bit_cnt <= '0;
        end else if (baud_done) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // lsb first, sampled mid-bit.
    always_ff @(posedge clk_i) begin
        if ((state == DATA) && baud_done) begin
            rx_shift <= {rx_s, rx_shift[DATA_WIDTH-1:1]};
        end
    end

    assign m_axis.tvalid = (state == STOP);
    assign m_axis.tdata  = rx_shift;

    // the byte is offered for one bit time at most.
    assert property (@(posedge clk_i) disable iff (!arstn_i)
        m_axis.tvalid |-> !$past(m_axis.tvalid, BAUD_RATIO));

endmodule

// ==== hw/axis_uart_tx.sv ====
`timescale 1ns/1ps

module axis_uart_tx (
    input  logic  clk_i,
    input  logic  arstn_i,
    axis_if.slave s_axis,
    output logic  tx_o
);

    import uart_regs_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        STOP
    } tx_state_t;

    tx_state_t              state;
    logic [BAUD_CNT_W-1:0]  baud_cnt;
    logic [FRAME_CNT_W-1:0] bit_cnt;
    logic [FRAME_BITS-1:0]  tx_shift;
    logic                   baud_tick;
    logic                   accept;

    assign s_axis.tready = (state == IDLE);
    assign accept        = s_axis.tvalid && s_axis.tready;
    assign baud_tick     = (baud_cnt == BAUD_CNT_W'(BAUD_RATIO - 1));

    // ============================================================
    // state machine
    // ============================================================
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= SEND;
                    end
                end
                SEND: begin
                    // the last tick of SEND puts the stop bit on the line.
                    if (baud_tick && (bit_cnt == FRAME_CNT_W'(FRAME_BITS - 1))) begin
                        state <= STOP;
                    end
                end
                STOP: begin
                    if (baud_tick) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // parked on a tick so the start bit goes out right away.
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= BAUD_CNT_W'(BAUD_RATIO - 1);
        end else if (state == IDLE) begin
            baud_cnt <= BAUD_CNT_W'(BAUD_RATIO - 1);
        end else if (baud_tick) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            bit_cnt <= '0;
        end else if (state == IDLE) begin
            bit_cnt <= '0;
        end else if ((state == SEND) && baud_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // framed character, start bit in the lsb.
    always_ff @(posedge clk_i) begin
        if (accept) begin
            tx_shift <= {1'b1, s_axis.tdata, 1'b0};
        end else if ((state == SEND) && baud_tick) begin
            tx_shift <= {1'b1, tx_shift[FRAME_BITS-1:1]};
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            tx_o <= 1'b1;   // line idles high.
        end else if ((state == SEND) && baud_tick) begin
            tx_o <= tx_shift[0];
        end
    end

    // every bit stays on the line for a full bit time.
    assert property (@(posedge clk_i) disable iff (!arstn_i)
        (tx_o != $past(tx_o)) |-> ($past(tx_o, BAUD_RATIO) == $past(tx_o)));

endmodule

// ==== hw/uart_cmd_ctrl.sv ====
`timescale 1ns/1ps

module uart_cmd_ctrl (
    input  logic   clk_i,
    input  logic   arstn_i,
    axis_if.slave  rx_axis,
    axis_if.master tx_axis,
    reg_if.master  bus
);

    import uart_regs_pkg::*;

    typedef enum logic [2:0] {
        GET_CMD,
        GET_DATA,
        REQ,
        WAIT_ACK_LOW,
        SEND_REPLY
    } ctrl_state_t;

    ctrl_state_t state;
    byte_t       reply;
    logic        rx_fire;
    logic        tx_fire;
    logic        rsvd_set;
    logic        is_write;

    assign rx_axis.tready = (state == GET_CMD) || (state == GET_DATA);
    assign rx_fire        = rx_axis.tvalid && rx_axis.tready;
    assign tx_fire        = tx_axis.tvalid && tx_axis.tready;

    // command decode.
    assign rsvd_set = |(rx_axis.tdata & CMD_RSVD_MASK);
    assign is_write = rx_axis.tdata[CMD_WRITE_BIT];

    // ============================================================
    // state machine
    // ============================================================
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state <= GET_CMD;
        end else begin
            case (state)
                GET_CMD: begin
                    if (rx_fire) begin
                        if (rsvd_set) begin
                            state <= SEND_REPLY;   // nak, no data byte follows.
                        end else if (is_write) begin
                            state <= GET_DATA;
                        end else begin
                            state <= REQ;
                        end
                    end
                end
                GET_DATA: begin
                    if (rx_fire) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (bus.ack) begin
                        state <= WAIT_ACK_LOW;
                    end
                end
                WAIT_ACK_LOW: begin
                    if (!bus.ack) begin
                        state <= SEND_REPLY;
                    end
                end
                SEND_REPLY: begin
                    if (tx_fire) begin
                        state <= GET_CMD;
                    end
                end
                default: state <= GET_CMD;
            endcase
        end
    end

    // ============================================================
    // access fields and reply byte
    // ============================================================
    always_ff @(posedge clk_i) begin
        if ((state == GET_CMD) && rx_fire) begin
            bus.addr <= reg_addr_t'(rx_axis.tdata);
            bus.we   <= is_write;
            if (rsvd_set) begin
                reply <= REPLY_NAK;
            end
        end
        if ((state == GET_DATA) && rx_fire) begin
            bus.wdata <= rx_axis.tdata;
        end
        if ((state == REQ) && bus.ack) begin
            reply <= bus.we ? REPLY_ACK : bus.rdata;
        end
    end

    assign bus.req        = (state == REQ);
    assign tx_axis.tvalid = (state == SEND_REPLY);
    assign tx_axis.tdata  = reply;

    // the bank must answer before the request is withdrawn.
    assert property (@(posedge clk_i) disable iff (!arstn_i)
        $fell(bus.req) |-> bus.ack);

endmodule

// ==== hw/reg_bank.sv ====
`timescale 1ns/1ps

module reg_bank (
    input  logic clk_i,
    input  logic arstn_i,
    reg_if.slave bus
);

    import uart_regs_pkg::*;

    byte_t regs [REG_COUNT];
    logic  req_rise;

    // ack follows req by a cycle, so req high with ack low is a new request.
    assign req_rise = bus.req && !bus.ack;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            bus.ack <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            bus.ack <= bus.req;
            if (req_rise && bus.we) begin
                regs[bus.addr] <= bus.wdata;
            end
        end
    end

    // read data settles together with ack.
    always_ff @(posedge clk_i) begin
        if (req_rise) begin
            bus.rdata <= regs[bus.addr];
        end
    end

    assert property (@(posedge clk_i) disable iff (!arstn_i)
        $rose(bus.ack) |-> bus.req);

endmodule

// ==== hw/uart_regs_top.sv ====
`timescale 1ns/1ps

module uart_regs_top (
    input  logic clk_i,
    input  logic arstn_i,
    input  logic rx_i,
    output logic tx_o
);

    axis_if rx_axis ();
    axis_if tx_axis ();
    reg_if  reg_bus ();

    // ============================================================
    // serial line to command stream and back
    // ============================================================
    axis_uart_rx u_rx (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .rx_i    (rx_i),
        .m_axis  (rx_axis)
    );

    uart_cmd_ctrl u_ctrl (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .rx_axis (rx_axis),
        .tx_axis (tx_axis),
        .bus     (reg_bus)
    );

    axis_uart_tx u_tx (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .s_axis  (tx_axis),
        .tx_o    (tx_o)
    );

    reg_bank u_regs (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .bus     (reg_bus)
    );

endmodule

// ==== testbench/tb_uart_regs.sv ====
`timescale 1ns/1ps

module tb_uart_regs;

    import uart_regs_pkg::*;

    localparam byte_t ACK_BYTE      = 8'hA5;
    localparam byte_t NAK_BYTE      = 8'h5A;
    localparam int    QUIET_BITS    = 40;
    localparam int    REPLY_TIMEOUT = 60 * BAUD_RATIO;   // cycles.

    logic   clk_i;
    logic   arstn_i;
    logic   rx_i;
    logic   tx_o;
    int     error_count;
    integer seed = 32'h9d2d3e03;
    byte_t  model [16];

    uart_regs_top uut (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .rx_i    (rx_i),
        .tx_o    (tx_o)
    );

    always #20 clk_i = ~clk_i;

    // ============================================================
    // serial driver and monitor
    // ============================================================
    task automatic send_byte(input byte_t data);
        int i;
        rx_i = 1'b0;
        repeat (BAUD_RATIO) @(negedge clk_i);
        for (i = 0; i < 8; i++) begin
            rx_i = data[i];   // lsb first.
            repeat (BAUD_RATIO) @(negedge clk_i);
        end
        rx_i = 1'b1;
        repeat (BAUD_RATIO) @(negedge clk_i);
    endtask

    task automatic recv_byte(output byte_t data, output bit ok);
        int   waited;
        int   i;
        logic prev;
        logic found;
        ok     = 1'b0;
        data   = '0;
        waited = 0;
        found  = 1'b0;
        prev   = tx_o;
        while (!found && (waited < REPLY_TIMEOUT)) begin
            @(negedge clk_i);
            found = prev && !tx_o;
            prev  = tx_o;
            waited++;
        end
        if (!found) begin
            $display("no start bit on tx_o within %0d cycles", REPLY_TIMEOUT);
            error_count++;
        end else begin
            repeat (BAUD_RATIO / 2) @(negedge clk_i);   // middle of the start bit.
            for (i = 0; i < 8; i++) begin
                repeat (BAUD_RATIO) @(negedge clk_i);
                data[i] = tx_o;
            end
            repeat (BAUD_RATIO) @(negedge clk_i);
            if (tx_o !== 1'b1) begin
                $display("stop bit missing on tx_o after reply byte %02h", data);
                error_count++;
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic check_reply(input byte_t cmd, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            $display("[ERROR] tx_o reply to cmd %02h: expected %02h, actual %02h",
                     cmd, expected, actual);
            error_count++;
        end
    endtask

    task automatic expect_quiet(input int bits);
        int i;
        for (i = 0; i < bits * BAUD_RATIO; i++) begin
            @(negedge clk_i);
            if (tx_o !== 1'b1) begin
                $display("[ERROR] tx_o while idle: expected 1, actual %h", tx_o);
                error_count++;
                break;
            end
        end
    endtask

    // ============================================================
    // register accesses
    // ============================================================
    task automatic write_reg(input reg_addr_t addr, input byte_t data);
        byte_t cmd;
        byte_t reply;
        bit    ok;
        cmd = {4'h8, addr};
        model[addr] = data;
        fork
            begin
                send_byte(cmd);
                send_byte(data);
            end
            recv_byte(reply, ok);
        join
        if (ok) check_reply(cmd, ACK_BYTE, reply);
    endtask

    task automatic read_reg(input reg_addr_t addr);
        byte_t cmd;
        byte_t reply;
        bit    ok;
        cmd = {4'h0, addr};
        fork
            send_byte(cmd);
            recv_byte(reply, ok);
        join
        if (ok) check_reply(cmd, model[addr], reply);
    endtask

    task automatic send_bad_cmd(input byte_t cmd);
        byte_t reply;
        bit    ok;
        fork
            send_byte(cmd);
            recv_byte(reply, ok);
        join
        if (ok) check_reply(cmd, NAK_BYTE, reply);
    endtask

    // ============================================================
    // directed tests
    // ============================================================
    task automatic test_reset_state();
        expect_quiet(QUIET_BITS);
        read_reg(4'd3);
    endtask

    task automatic test_write_read();
        write_reg(4'd5, 8'h3C);
        read_reg(4'd5);
    endtask

    task automatic test_all_regs();
        int i;
        for (i = 0; i < 16; i++) begin
            write_reg(reg_addr_t'(i), byte_t'($random(seed)));
        end
        // stride 7 visits every address once.
        for (i = 0; i < 16; i++) begin
            read_reg(reg_addr_t'((i * 7 + 3) % 16));
        end
    endtask

    task automatic test_reserved_cmds();
        byte_t bad [3];
        int    i;
        bad[0] = 8'h90;
        bad[1] = 8'h4A;
        bad[2] = 8'hF3;
        for (i = 0; i < 3; i++) begin
            send_bad_cmd(bad[i]);
        end
        for (i = 0; i < 3; i++) begin
            read_reg(reg_addr_t'(bad[i]));   // apparent target, low nibble.
        end
    endtask

    task automatic test_start_glitch();
        rx_i = 1'b0;
        repeat (6) @(negedge clk_i);        // well under a third of a bit.
        rx_i = 1'b1;
        expect_quiet(QUIET_BITS);
        read_reg(4'd9);
    endtask

    task automatic test_back_to_back();
        byte_t data;
        byte_t r0;
        byte_t r1;
        bit    ok0;
        bit    ok1;
        data = byte_t'($random(seed));
        model[12] = data;
        fork
            begin
                send_byte(8'h8C);
                send_byte(data);
                send_byte(8'h0C);
            end
            begin
                recv_byte(r0, ok0);
                recv_byte(r1, ok1);
            end
        join
        if (ok0) check_reply(8'h8C, ACK_BYTE, r0);
        if (ok1) check_reply(8'h0C, data, r1);
    endtask

    initial begin
        clk_i       = 1'b0;
        arstn_i     = 1'b0;
        rx_i        = 1'b1;   // idle line.
        error_count = 0;
        for (int i = 0; i < 16; i++) begin
            model[i] = '0;
        end
        repeat (8) @(negedge clk_i);
        arstn_i = 1'b1;
        repeat (4) @(negedge clk_i);

        test_reset_state();
        test_write_read();
        test_all_regs();
        test_reserved_cmds();
        test_start_glitch();
        test_back_to_back();

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== uart_regs.f ====
hw/uart_regs_pkg.sv
hw/bus_ifs.sv
hw/axis_uart_rx.sv
hw/axis_uart_tx.sv
hw/uart_cmd_ctrl.sv
hw/reg_bank.sv
hw/uart_regs_top.sv
testbench/tb_uart_regs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the uart_regs testbench with verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_uart_regs_sim

verilator --binary --timing --assert \
    --top-module tb_uart_regs \
    -f uart_regs.f \
    -o "$BIN"
if [ $? -ne 0 ]; then
    echo "FAIL: verilator build error"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "FAIL: simulation exited with status $status"
    exit 1
fi

# the verdict comes from the log.
if grep -q "Simulation failed" "$LOG"; then
    echo "FAIL: see $LOG"
    exit 1
fi

echo "PASS"
exit 0
